// ==== source/uart_console_pkg.sv ====
`default_nettype none

package uart_console_pkg;

  // ---------------------------------------------------------
  // Data path
  // ---------------------------------------------------------

  // Width of every byte path in the console.
  localparam int byte_w = 8;

  // Clock cycles per serial bit.
  // A 100 MHz clock at 115200 baud needs 868; 8 keeps simulation short.
  localparam int clks_per_bit = 8;

  // ---------------------------------------------------------
  // FIFO and banner
  // ---------------------------------------------------------

  // Entry count must stay a power of two so the pointers wrap on their own.
  localparam int fifo_depth = 16;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  // "Hello, Fifo!!" plus CR LF.
  localparam int banner_len = 15;

  // ---------------------------------------------------------
  // Transmitter state encoding
  // ---------------------------------------------------------

  localparam logic [1:0] tx_idle  = 2'd0;
  localparam logic [1:0] tx_start = 2'd1;
  localparam logic [1:0] tx_data  = 2'd2;
  localparam logic [1:0] tx_stop  = 2'd3;

endpackage

`default_nettype wire

// ==== source/byte_fifo.sv ====
`default_nettype none

module byte_fifo (
  input  logic                                CLK,
  input  logic                                rst,
  input  logic                                wr_en,
  input  logic [uart_console_pkg::byte_w-1:0] wr_data,
  input  logic                                rd_en,
  output logic [uart_console_pkg::byte_w-1:0] rd_data,
  output logic                                empty,
  output logic                                full
);

  logic [uart_console_pkg::byte_w-1:0]     mem [uart_console_pkg::fifo_depth];
  logic [uart_console_pkg::fifo_ptr_w-1:0] wr_ptr;
  logic [uart_console_pkg::fifo_ptr_w-1:0] rd_ptr;
  logic [uart_console_pkg::fifo_ptr_w-1:0] rd_ptr_next;
  logic [uart_console_pkg::fifo_ptr_w:0]   count;
  logic                                    do_wr;
  logic                                    do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign empty = (count == '0);
  assign full  = (count == (uart_console_pkg::fifo_ptr_w + 1)'(uart_console_pkg::fifo_depth));

  // Head position once this cycle's pop has taken effect.
  assign rd_ptr_next = do_rd ? rd_ptr + 1'b1 : rd_ptr;

  // ---------------------------------------------------------
  // Pointers and occupancy
  // ---------------------------------------------------------

  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr_next;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ---------------------------------------------------------
  // Storage and head register
  // ---------------------------------------------------------

  always_ff @(posedge CLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // The head register looks one edge ahead. A write landing on the new head
  // slot can only happen when the FIFO drains to empty, so it is forwarded.
  always_ff @(posedge CLK) begin
    if (do_wr && (wr_ptr == rd_ptr_next)) begin
      rd_data <= wr_data;
    end else begin
      rd_data <= mem[rd_ptr_next];
    end
  end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
`default_nettype none

module uart_tx (
  input  logic                                CLK,
  input  logic                                rst,
  input  logic                                tx_en,
  input  logic [uart_console_pkg::byte_w-1:0] data,
  output logic                                tx_ready,
  output logic                                tx
);

  logic [1:0]                                        state;
  logic [$clog2(uart_console_pkg::clks_per_bit)-1:0] bit_cnt;
  logic [$clog2(uart_console_pkg::byte_w)-1:0]       bit_idx;
  logic [uart_console_pkg::byte_w-1:0]               shift_reg;
  logic                                              bit_last;
  logic                                              byte_last;
  logic                                              load;

  assign bit_last = (bit_cnt ==
      ($clog2(uart_console_pkg::clks_per_bit))'(uart_console_pkg::clks_per_bit - 1));
  assign byte_last = (bit_idx ==
      ($clog2(uart_console_pkg::byte_w))'(uart_console_pkg::byte_w - 1));

  assign tx_ready = (state == uart_console_pkg::tx_idle);
  assign load     = tx_en && tx_ready;

  // ---------------------------------------------------------
  // Frame sequencing
  // ---------------------------------------------------------

  always_ff @(posedge CLK) begin
    if (rst) begin
      state   <= uart_console_pkg::tx_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
    end else begin
      case (state)
        uart_console_pkg::tx_idle: begin
          bit_cnt <= '0;
          bit_idx <= '0;
          if (load) begin
            state <= uart_console_pkg::tx_start;
          end
        end
        uart_console_pkg::tx_start: begin
          if (bit_last) begin
            bit_cnt <= '0;
            state   <= uart_console_pkg::tx_data;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        uart_console_pkg::tx_data: begin
          if (bit_last) begin
            bit_cnt <= '0;
            if (byte_last) begin
              state <= uart_console_pkg::tx_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: begin
          if (bit_last) begin
            bit_cnt <= '0;
            state   <= uart_console_pkg::tx_idle;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Data goes out LSB first, so the shifter moves right once per bit.
  always_ff @(posedge CLK) begin
    if (load) begin
      shift_reg <= data;
    end else if ((state == uart_console_pkg::tx_data) && bit_last) begin
      shift_reg <= {1'b1, shift_reg[uart_console_pkg::byte_w-1:1]};
    end
  end

  always_comb begin
    case (state)
      uart_console_pkg::tx_start: tx = 1'b0;
      uart_console_pkg::tx_data:  tx = shift_reg[0];
      default:                    tx = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/banner_sender.sv ====
`default_nettype none

module banner_sender (
  input  logic                                CLK,
  input  logic                                rst,
  input  logic                                banner_start,
  input  logic                                banner_grant,
  output logic                                banner_req,
  output logic [uart_console_pkg::byte_w-1:0] banner_byte
);

  logic                                            active;
  logic                                            boot;
  logic [$clog2(uart_console_pkg::banner_len)-1:0] idx;
  logic                                            idx_last;

  // The greeting table ends in CR LF.
  function automatic logic [uart_console_pkg::byte_w-1:0] banner_char(
    input logic [$clog2(uart_console_pkg::banner_len)-1:0] i
  );
    case (i)
      0:       banner_char = "H";
      1:       banner_char = "e";
      2:       banner_char = "l";
      3:       banner_char = "l";
      4:       banner_char = "o";
      5:       banner_char = ",";
      6:       banner_char = " ";
      7:       banner_char = "F";
      8:       banner_char = "i";
      9:       banner_char = "f";
      10:      banner_char = "o";
      11:      banner_char = "!";
      12:      banner_char = "!";
      13:      banner_char = 8'h0D;
      14:      banner_char = 8'h0A;
      default: banner_char = 8'h00;
    endcase
  endfunction

  assign idx_last = (idx ==
      ($clog2(uart_console_pkg::banner_len))'(uart_console_pkg::banner_len - 1));

  assign banner_req  = active;
  assign banner_byte = banner_char(idx);

  // The first edge after reset starts the greeting on its own.
  always_ff @(posedge CLK) begin
    if (rst) begin
      active <= 1'b0;
      boot   <= 1'b1;
      idx    <= '0;
    end else begin
      boot <= 1'b0;
      if (active) begin
        if (banner_grant) begin
          if (idx_last) begin
            active <= 1'b0;
            idx    <= '0;
          end else begin
            idx <= idx + 1'b1;
          end
        end
      end else if (banner_start || boot) begin
        active <= 1'b1;
        idx    <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/fifo_write_arbiter.sv ====
`default_nettype none

module fifo_write_arbiter (
  input  logic                                CLK,
  input  logic                                rst,
  input  logic                                banner_req,
  input  logic [uart_console_pkg::byte_w-1:0] banner_byte,
  input  logic [uart_console_pkg::byte_w-1:0] host_byte,
  input  logic                                host_write,
  input  logic                                fifo_full,
  output logic                                banner_grant,
  output logic                                host_busy,
  output logic                                wr_en,
  output logic [uart_console_pkg::byte_w-1:0] wr_data
);

  logic                                host_valid;
  logic [uart_console_pkg::byte_w-1:0] host_data;
  logic                                last_host;
  logic                                pick_host;
  logic                                host_grant;

  assign host_busy = host_valid;

  // ---------------------------------------------------------
  // Round-robin choice
  // ---------------------------------------------------------

  // The host wins a tie only if the banner was served last.
  assign pick_host = host_valid && (!banner_req || !last_host);

  assign host_grant   = pick_host && !fifo_full;
  assign banner_grant = banner_req && !pick_host && !fifo_full;

  assign wr_en   = host_grant || banner_grant;
  assign wr_data = host_grant ? host_data : banner_byte;

  // ---------------------------------------------------------
  // Host holding register and fairness state
  // ---------------------------------------------------------

  always_ff @(posedge CLK) begin
    if (rst) begin
      host_valid <= 1'b0;
      last_host  <= 1'b0;
    end else begin
      if (host_grant) begin
        host_valid <= 1'b0;
        last_host  <= 1'b1;
      end else if (host_write && !host_valid) begin
        host_valid <= 1'b1;
      end
      if (banner_grant) begin
        last_host <= 1'b0;
      end
    end
  end

  // A write seen while busy is dropped, even in the cycle the register drains.
  always_ff @(posedge CLK) begin
    if (host_write && !host_valid) begin
      host_data <= host_byte;
    end
  end

endmodule

`default_nettype wire

// ==== source/uart_console_top.sv ====
`default_nettype none

module uart_console_top (
  input  logic                                CLK,
  input  logic                                rst,
  input  logic                                banner_start,
  input  logic [uart_console_pkg::byte_w-1:0] host_byte,
  input  logic                                host_write,
  output logic                                host_busy,
  output logic                                tx,
  output logic                                fifo_full
);

  logic                                banner_req;
  logic [uart_console_pkg::byte_w-1:0] banner_byte;
  logic                                banner_grant;
  logic                                wr_en;
  logic [uart_console_pkg::byte_w-1:0] wr_data;
  logic [uart_console_pkg::byte_w-1:0] rd_data;
  logic                                rd_en;
  logic                                fifo_empty;
  logic                                tx_en;
  logic                                tx_ready;

  // ---------------------------------------------------------
  // Producers
  // ---------------------------------------------------------

  banner_sender banner_inst (
    .CLK          (CLK),
    .rst          (rst),
    .banner_start (banner_start),
    .banner_grant (banner_grant),
    .banner_req   (banner_req),
    .banner_byte  (banner_byte)
  );

  fifo_write_arbiter arbiter_inst (
    .CLK          (CLK),
    .rst          (rst),
    .banner_req   (banner_req),
    .banner_byte  (banner_byte),
    .host_byte    (host_byte),
    .host_write   (host_write),
    .fifo_full    (fifo_full),
    .banner_grant (banner_grant),
    .host_busy    (host_busy),
    .wr_en        (wr_en),
    .wr_data      (wr_data)
  );

  // ---------------------------------------------------------
  // Queue and serial output
  // ---------------------------------------------------------

  byte_fifo fifo_inst (
    .CLK     (CLK),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .empty   (fifo_empty),
    .full    (fifo_full)
  );

  // The head leaves the FIFO on the same edge the transmitter loads it.
  assign tx_en = !fifo_empty;
  assign rd_en = tx_ready && !fifo_empty;

  uart_tx tx_inst (
    .CLK      (CLK),
    .rst      (rst),
    .tx_en    (tx_en),
    .data     (rd_data),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

endmodule

`default_nettype wire

// ==== dv/uart_console_assertions.sv ====
`default_nettype none

module uart_console_assertions (
  input logic CLK,
  input logic rst,
  input logic wr_en,
  input logic fifo_full,
  input logic banner_grant,
  input logic host_busy,
  input logic tx_ready,
  input logic tx
);

  // ---------------------------------------------------------
  // FIFO write port
  // ---------------------------------------------------------

  write_blocked_when_full: assert property (
    @(posedge CLK) disable iff (rst) !(wr_en && fifo_full)
  ) else $error("FIFO written while full");

  // A host grant always empties the holding register. So a banner grant made
  // while the register is full has to leave host_busy high.
  single_grant: assert property (
    @(posedge CLK) disable iff (rst) (banner_grant && host_busy) |=> host_busy
  ) else $error("Banner and host granted in the same cycle");

  // ---------------------------------------------------------
  // Serial line
  // ---------------------------------------------------------

  line_high_when_idle: assert property (
    @(posedge CLK) disable iff (rst) tx_ready |-> tx
  ) else $error("Serial line low while the transmitter is idle");

endmodule

bind uart_console_top uart_console_assertions assertions_inst (
  .CLK          (CLK),
  .rst          (rst),
  .wr_en        (wr_en),
  .fifo_full    (fifo_full),
  .banner_grant (banner_grant),
  .host_busy    (host_busy),
  .tx_ready     (tx_ready),
  .tx           (tx)
);

`default_nettype wire

// ==== dv/uart_console_tb.sv ====
`default_nettype none

module uart_console_tb;

  localparam int cpb        = uart_console_pkg::clks_per_bit;
  localparam int frame_clks = 10 * cpb;
  localparam int mid_off    = cpb / 2 - 1;

  // Banner column of the stimulus table.
  localparam logic [1:0] bn_none    = 2'd0;
  localparam logic [1:0] bn_new     = 2'd1;
  localparam logic [1:0] bn_ignored = 2'd2;

  typedef logic [uart_console_pkg::byte_w-1:0] byte_t;

  typedef struct packed {
    logic [2:0] test;
    byte_t      host_byte;
    logic       host_write;
    logic [1:0] banner;
    logic [3:0] gap;
  } step_t;

  logic  CLK;
  logic  rst;
  logic  banner_start;
  byte_t host_byte;
  logic  host_write;
  logic  host_busy;
  logic  tx;
  logic  fifo_full;

  string greeting = "Hello, Fifo!!\r\n";
  byte_t host_exp[$];
  byte_t banner_exp[$];
  step_t steps[19];
  int    n_checks = 0;
  int    n_errors = 0;
  logic  rx_busy = 1'b0;
  int    rx_cnt = 0;
  byte_t rx_shift = '0;
  int    quiet_cnt = 0;
  logic  saw_full = 1'b0;

  uart_console_top uut (
    .CLK          (CLK),
    .rst          (rst),
    .banner_start (banner_start),
    .host_byte    (host_byte),
    .host_write   (host_write),
    .host_busy    (host_busy),
    .tx           (tx),
    .fifo_full    (fifo_full)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // ---------------------------------------------------------
  // Checks
  // ---------------------------------------------------------

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s = 8'h%02h, expected 8'h%02h", $time, name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_frame(input string bit_name, input logic level, input logic exp);
    n_checks++;
    if (level !== exp) begin
      n_errors++;
      $display("At %0t the %s bit of a frame was not %s", $time, bit_name,
               exp ? "high" : "low");
    end
  endtask

  task automatic report_problem(input string msg);
    n_checks++;
    n_errors++;
    $display("%s (time %0t)", msg, $time);
  endtask

  // Bit 7 tells host bytes apart from the ASCII greeting.
  task automatic sort_byte(input byte_t b);
    if (b[uart_console_pkg::byte_w-1]) begin
      if (host_exp.size() == 0) begin
        report_problem($sformatf("Host byte 8'h%02h arrived with none expected", b));
      end else begin
        check_byte("host byte", b, host_exp.pop_front());
      end
    end else if (banner_exp.size() == 0) begin
      report_problem($sformatf("Banner byte 8'h%02h arrived with none expected", b));
    end else begin
      check_byte("banner byte", b, banner_exp.pop_front());
    end
  endtask

  // ---------------------------------------------------------
  // Serial frame decoder
  // ---------------------------------------------------------

  // Samples at the falling edge, mid_off cycles into each bit.
  always @(negedge CLK) begin
    int bit_no;
    if (rst) begin
      rx_busy   = 1'b0;
      quiet_cnt = 0;
    end else if (!rx_busy) begin
      if (tx == 1'b0) begin
        rx_busy   = 1'b1;
        rx_cnt    = 0;
        quiet_cnt = 0;
      end else begin
        quiet_cnt++;
      end
    end else begin
      rx_cnt++;
      if (rx_cnt >= mid_off && (rx_cnt - mid_off) % cpb == 0) begin
        bit_no = (rx_cnt - mid_off) / cpb;
        if (bit_no == 0) begin
          check_frame("start", tx, 1'b0);
        end else if (bit_no <= uart_console_pkg::byte_w) begin
          rx_shift = {tx, rx_shift[uart_console_pkg::byte_w-1:1]};
        end else begin
          check_frame("stop", tx, 1'b1);
          sort_byte(rx_shift);
          rx_busy = 1'b0;
        end
      end
    end
    if (fifo_full === 1'b1) begin
      saw_full = 1'b1;
    end
  end

  // ---------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------

  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic push_greeting();
    for (int i = 0; i < uart_console_pkg::banner_len; i++) begin
      banner_exp.push_back(byte_t'(greeting[i]));
    end
  endtask

  function automatic logic drained();
    return host_exp.size() == 0 && banner_exp.size() == 0 && quiet_cnt >= 2 * frame_clks;
  endfunction

  task automatic wait_banner_done(input int limit);
    int n;
    n = 0;
    while (banner_exp.size() != 0 && n < limit) begin
      next_cycle();
      n++;
    end
    if (banner_exp.size() != 0) begin
      report_problem("Timed out waiting for the greeting to arrive");
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (!drained() && n < limit) begin
      next_cycle();
      n++;
    end
    if (!drained()) begin
      report_problem("Timed out waiting for the serial line to go quiet");
    end
  endtask

  // A write is taken only if host_busy is low in the cycle it is driven.
  task automatic apply_step(input step_t s);
    logic taken;
    int   gap;
    if (s.banner == bn_new) begin
      wait_banner_done(40 * frame_clks);
    end
    taken        = s.host_write && !host_busy;
    host_byte    = s.host_byte;
    host_write   = s.host_write;
    banner_start = (s.banner != bn_none);
    if (taken) begin
      host_exp.push_back(s.host_byte);
    end
    if (s.banner == bn_new) begin
      push_greeting();
    end
    next_cycle();
    host_write   = 1'b0;
    banner_start = 1'b0;
    if (taken) begin
      check_level("host_busy", host_busy, 1'b1);
    end
    gap = (s.gap == 0) ? 0 : int'(s.gap) + int'($urandom_range(3, 0));
    repeat (gap) next_cycle();
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (n_errors == errs_before) begin
      $display("Test %0d, %s: ok", num, name);
    end else begin
      $display("Test %0d, %s: %0d errors", num, name, n_errors - errs_before);
    end
  endtask

  initial begin
    int errs;
    void'($urandom(32'h002c_d47b));
    rst          = 1'b1;
    banner_start = 1'b0;
    host_byte    = '0;
    host_write   = 1'b0;
    steps = '{
      '{3'd3, 8'h81, 1'b1, bn_none, 4'd2},
      '{3'd3, 8'h82, 1'b1, bn_none, 4'd0},
      '{3'd3, 8'h83, 1'b1, bn_none, 4'd0},
      '{3'd3, 8'h84, 1'b0, bn_none, 4'd1},
      '{3'd3, 8'h85, 1'b1, bn_none, 4'd3},
      '{3'd4, 8'h90, 1'b0, bn_new, 4'd1},
      '{3'd4, 8'h91, 1'b1, bn_ignored, 4'd0},
      '{3'd4, 8'h92, 1'b1, bn_none, 4'd1},
      '{3'd4, 8'h93, 1'b1, bn_ignored, 4'd2},
      '{3'd5, 8'ha0, 1'b1, bn_new, 4'd0},
      '{3'd5, 8'ha1, 1'b1, bn_none, 4'd0},
      '{3'd5, 8'ha2, 1'b1, bn_none, 4'd0},
      '{3'd5, 8'ha3, 1'b1, bn_none, 4'd0},
      '{3'd5, 8'ha4, 1'b1, bn_none, 4'd0},
      '{3'd5, 8'ha5, 1'b1, bn_none, 4'd0},
      '{3'd5, 8'ha6, 1'b1, bn_none, 4'd0},
      '{3'd5, 8'ha7, 1'b1, bn_none, 4'd0},
      '{3'd5, 8'ha8, 1'b1, bn_none, 4'd0},
      '{3'd5, 8'ha9, 1'b1, bn_none, 4'd0}
    };
    // The greeting goes out by itself once reset is released.
    push_greeting();
    repeat (2) @(posedge CLK);
    #2;
    rst = 1'b0;

    errs = n_errors;
    check_level("tx", tx, 1'b1);
    check_level("host_busy", host_busy, 1'b0);
    check_level("fifo_full", fifo_full, 1'b0);
    report_test(1, "state after reset", errs);

    errs = n_errors;
    wait_drain(50 * frame_clks);
    report_test(2, "automatic greeting", errs);

    for (int t = 3; t <= 5; t++) begin
      errs     = n_errors;
      saw_full = 1'b0;
      foreach (steps[i]) begin
        if (int'(steps[i].test) == t) begin
          apply_step(steps[i]);
        end
      end
      wait_drain(50 * frame_clks);
      if (t == 5) begin
        check_level("fifo_full seen high", saw_full, 1'b1);
      end
      report_test(t, t == 3 ? "host order" : (t == 4 ? "banner restart" : "full FIFO burst"),
                  errs);
    end

    $display("Checks run: %0d, failed: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/uart_console_pkg.sv
source/byte_fifo.sv
source/uart_tx.sv
source/banner_sender.sv
source/fifo_write_arbiter.sv
source/uart_console_top.sv
dv/uart_console_assertions.sv
dv/uart_console_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module uart_console_tb -f files.f

./obj_dir/Vuart_console_tb 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
